//--- common/mbiu_pkg.sv
`default_nettype none

package mbiu_pkg;

   // ----------------------------------------------------------------------
   // bus and field widths
   // ----------------------------------------------------------------------
   localparam int ADDR_W    = 32;
   localparam int DATA_W    = 64;
   localparam int ID_W      = 3;
   localparam int TAG_W     = 5;
   // byte lane within one 64 bit beat
   localparam int OFFS_W    = 3;
   // port 0 data, port 1 instruction
   localparam int NUM_PORTS = 2;

   // ----------------------------------------------------------------------
   // vector types
   // ----------------------------------------------------------------------
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ID_W-1:0]   axi_id_t;
   // destination register of the load
   typedef logic [TAG_W-1:0]  tag_t;
   // 0 byte, 1 half, 2 word, 3 double
   typedef logic [1:0]        size_t;
   typedef logic [OFFS_W-1:0] offs_t;
   // [0] privileged, [1] non-secure, [2] instruction
   typedef logic [2:0]        prot_t;

   // ----------------------------------------------------------------------
   // fixed AR field values
   // ----------------------------------------------------------------------
   // highest id reserved for port 0, forces in-order return
   localparam axi_id_t    ID_PORT0     = axi_id_t'(2**ID_W - 1);
   // 8 bytes per beat
   localparam logic [2:0] ARSIZE_BEAT  = 3'd3;
   // single beat only
   localparam logic [7:0] ARLEN_SINGLE = 8'd0;
   localparam logic [1:0] ARBURST_INCR = 2'd1;
   // bufferable
   localparam logic [3:0] ARCACHE_BUF  = 4'd1;
   localparam prot_t      PROT_DATA    = 3'd0;
   localparam prot_t      PROT_INST    = 3'd4;

endpackage

`default_nettype wire

//--- hw/mbiu_req_buf.sv
`timescale 1ns/1ps
`default_nettype none

module mbiu_req_buf (
   input  logic              clk,
   input  logic              rstn,
   // core side
   input  logic              in_val,
   output logic              in_rdy,
   input  mbiu_pkg::addr_t   in_addr,
   input  mbiu_pkg::tag_t    in_tag,
   input  mbiu_pkg::size_t   in_size,
   input  logic              in_signed,
   // arbiter side
   output logic              out_val,
   input  logic              out_rdy,
   output mbiu_pkg::addr_t   out_addr,
   output mbiu_pkg::tag_t    out_tag,
   output mbiu_pkg::size_t   out_size,
   output logic              out_signed
);

   // empty, or drained this cycle
   assign in_rdy = !out_val || out_rdy;

   // valid flag
   always_ff @(posedge clk) begin
      if (!rstn) begin
         out_val <= 1'b0;
      end else if (in_rdy) begin
         out_val <= in_val;
      end
   end

   // payload, held under back-pressure
   always_ff @(posedge clk) begin
      if (in_val && in_rdy) begin
         out_addr   <= in_addr;
         out_tag    <= in_tag;
         out_size   <= in_size;
         out_signed <= in_signed;
      end
   end

endmodule

`default_nettype wire

//--- hw/mbiu_rd_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mbiu_rd_issue (
   input  logic                clk,
   input  logic                rstn,
   // port 0 request buffer
   input  logic                buf0_val,
   output logic                buf0_rdy,
   input  mbiu_pkg::addr_t     buf0_addr,
   input  mbiu_pkg::tag_t      buf0_tag,
   input  mbiu_pkg::size_t     buf0_size,
   input  logic                buf0_signed,
   // port 1 request buffer
   input  logic                buf1_val,
   output logic                buf1_rdy,
   input  mbiu_pkg::addr_t     buf1_addr,
   input  mbiu_pkg::tag_t      buf1_tag,
   input  mbiu_pkg::size_t     buf1_size,
   input  logic                buf1_signed,
   // from tracking
   input  logic                port0_space,
   input  logic                port1_done,
   // AXI read address channel
   output logic                arvalid,
   input  logic                arready,
   output mbiu_pkg::axi_id_t   arid,
   output mbiu_pkg::addr_t     araddr,
   output logic [7:0]          arlen,
   output logic [2:0]          arsize,
   output logic [1:0]          arburst,
   output logic [3:0]          arcache,
   output mbiu_pkg::prot_t     arprot,
   // grant report to tracking
   output logic                issue_val,
   output logic                issue_port,
   output mbiu_pkg::axi_id_t   issue_id,
   output mbiu_pkg::offs_t     issue_offs,
   output mbiu_pkg::tag_t      issue_tag,
   output mbiu_pkg::size_t     issue_size,
   output logic                issue_signed
);

   // port 1 may use every id but the reserved one
   localparam int P1_MAX_OT = 2**mbiu_pkg::ID_W - 1;
   localparam mbiu_pkg::axi_id_t P1_LAST_ID = mbiu_pkg::axi_id_t'(P1_MAX_OT - 1);
   localparam mbiu_pkg::axi_id_t P1_MAX_CNT = mbiu_pkg::axi_id_t'(P1_MAX_OT);

   logic              ar_free;
   logic              cand0;
   logic              cand1;
   logic              grant0;
   logic              grant1;
   logic              prio1;
   mbiu_pkg::axi_id_t p1_id;
   mbiu_pkg::axi_id_t p1_ot;
   mbiu_pkg::addr_t   sel_addr;

   // ----------------------------------------------------------------------
   // round robin arbitration
   // ----------------------------------------------------------------------
   // AR register free now or emptied this cycle
   assign ar_free  = !arvalid || arready;
   assign cand0    = buf0_val && port0_space;
   assign cand1    = buf1_val && (p1_ot < P1_MAX_CNT);
   // prio1 set means port 1 wins a tie
   assign grant0   = ar_free && cand0 && (!prio1 || !cand1);
   assign grant1   = ar_free && cand1 && (prio1 || !cand0);
   assign buf0_rdy = grant0;
   assign buf1_rdy = grant1;

   // grant info to tracking
   assign sel_addr     = grant1 ? buf1_addr : buf0_addr;
   assign issue_val    = grant0 || grant1;
   assign issue_port   = grant1;
   assign issue_id     = grant1 ? p1_id : mbiu_pkg::ID_PORT0;
   assign issue_offs   = sel_addr[mbiu_pkg::OFFS_W-1:0];
   assign issue_tag    = grant1 ? buf1_tag : buf0_tag;
   assign issue_size   = grant1 ? buf1_size : buf0_size;
   assign issue_signed = grant1 ? buf1_signed : buf0_signed;

   // priority flip, port 1 id counter, port 1 in-flight count
   always_ff @(posedge clk) begin
      if (!rstn) begin
         prio1 <= 1'b0;
         p1_id <= '0;
         p1_ot <= '0;
      end else begin
         if (grant0) begin
            prio1 <= 1'b1;
         end else if (grant1) begin
            prio1 <= 1'b0;
         end
         // ids 0 to 6, wrap
         if (grant1) begin
            p1_id <= (p1_id == P1_LAST_ID) ? '0 : p1_id + 1'b1;
         end
         case ({grant1, port1_done})
            2'b10:   p1_ot <= p1_ot + 1'b1;
            2'b01:   p1_ot <= p1_ot - 1'b1;
            default: p1_ot <= p1_ot;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // AR output register
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rstn) begin
         arvalid <= 1'b0;
      end else if (issue_val) begin
         arvalid <= 1'b1;
      end else if (arready) begin
         arvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_val) begin
         arid   <= issue_id;
         araddr <= sel_addr;
         arprot <= grant1 ? mbiu_pkg::PROT_INST : mbiu_pkg::PROT_DATA;
      end
   end

   // single incr beat, full bus width
   assign arlen   = mbiu_pkg::ARLEN_SINGLE;
   assign arsize  = mbiu_pkg::ARSIZE_BEAT;
   assign arburst = mbiu_pkg::ARBURST_INCR;
   assign arcache = mbiu_pkg::ARCACHE_BUF;

endmodule

`default_nettype wire

//--- hw/mbiu_rd_track.sv
`timescale 1ns/1ps
`default_nettype none

module mbiu_rd_track #(
   parameter int PORT0_MAX_OT = 4
) (
   input  logic                clk,
   input  logic                rstn,
   // grant report
   input  logic                issue_val,
   input  logic                issue_port,
   input  mbiu_pkg::axi_id_t   issue_id,
   input  mbiu_pkg::offs_t     issue_offs,
   input  mbiu_pkg::tag_t      issue_tag,
   input  mbiu_pkg::size_t     issue_size,
   input  logic                issue_signed,
   output logic                port0_space,
   output logic                port1_done,
   // AXI read data channel
   input  logic                rvalid,
   output logic                rready,
   input  mbiu_pkg::axi_id_t   rid,
   input  mbiu_pkg::data_t     rdata,
   // port 0 response
   output logic                rsp0_val,
   input  logic                rsp0_rdy,
   output mbiu_pkg::data_t     rsp0_data,
   output mbiu_pkg::tag_t      rsp0_tag,
   output mbiu_pkg::size_t     rsp0_size,
   output logic                rsp0_signed,
   // port 1 response
   output logic                rsp1_val,
   input  logic                rsp1_rdy,
   output mbiu_pkg::data_t     rsp1_data,
   output mbiu_pkg::tag_t      rsp1_tag,
   output mbiu_pkg::size_t     rsp1_size,
   output logic                rsp1_signed
);

   localparam int PTR_W = (PORT0_MAX_OT > 1) ? $clog2(PORT0_MAX_OT) : 1;
   localparam int CNT_W = $clog2(PORT0_MAX_OT + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(PORT0_MAX_OT - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(PORT0_MAX_OT);
   localparam int P1_ENTRIES = 2**mbiu_pkg::ID_W;

   // port 0 in-order queue
   mbiu_pkg::offs_t   p0_offs   [PORT0_MAX_OT];
   mbiu_pkg::tag_t    p0_tag    [PORT0_MAX_OT];
   mbiu_pkg::size_t   p0_size   [PORT0_MAX_OT];
   logic              p0_signed [PORT0_MAX_OT];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  p0_cnt;
   logic              p0_push;
   logic              p0_pop;

   // port 1 table, indexed by id
   mbiu_pkg::offs_t   p1_offs   [P1_ENTRIES];
   mbiu_pkg::tag_t    p1_tag    [P1_ENTRIES];
   mbiu_pkg::size_t   p1_size   [P1_ENTRIES];
   logic              p1_signed [P1_ENTRIES];

   logic              is_p0;
   mbiu_pkg::offs_t   rsp_offs;
   mbiu_pkg::data_t   shifted;

   // ----------------------------------------------------------------------
   // read info store
   // ----------------------------------------------------------------------
   assign p0_push     = issue_val && !issue_port;
   assign p0_pop      = rvalid && is_p0 && rsp0_rdy;
   assign port0_space = (p0_cnt != FULL_CNT);

   always_ff @(posedge clk) begin
      if (p0_push) begin
         p0_offs[wr_ptr]   <= issue_offs;
         p0_tag[wr_ptr]    <= issue_tag;
         p0_size[wr_ptr]   <= issue_size;
         p0_signed[wr_ptr] <= issue_signed;
      end
      if (issue_val && issue_port) begin
         p1_offs[issue_id]   <= issue_offs;
         p1_tag[issue_id]    <= issue_tag;
         p1_size[issue_id]   <= issue_size;
         p1_signed[issue_id] <= issue_signed;
      end
   end

   // queue pointers and fill level
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         p0_cnt <= '0;
      end else begin
         if (p0_push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (p0_pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({p0_push, p0_pop})
            2'b10:   p0_cnt <= p0_cnt + 1'b1;
            2'b01:   p0_cnt <= p0_cnt - 1'b1;
            default: p0_cnt <= p0_cnt;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // R routing and alignment
   // ----------------------------------------------------------------------
   // reserved id marks port 0
   assign is_p0      = (rid == mbiu_pkg::ID_PORT0);
   assign rready     = is_p0 ? rsp0_rdy : rsp1_rdy;
   assign port1_done = rvalid && !is_p0 && rsp1_rdy;

   // requested bytes down to bit 0
   assign rsp_offs = is_p0 ? p0_offs[rd_ptr] : p1_offs[rid];
   assign shifted  = rdata >> {rsp_offs, 3'b000};

   assign rsp0_val    = rvalid && is_p0;
   assign rsp0_data   = shifted;
   assign rsp0_tag    = p0_tag[rd_ptr];
   assign rsp0_size   = p0_size[rd_ptr];
   assign rsp0_signed = p0_signed[rd_ptr];

   assign rsp1_val    = rvalid && !is_p0;
   assign rsp1_data   = shifted;
   assign rsp1_tag    = p1_tag[rid];
   assign rsp1_size   = p1_size[rid];
   assign rsp1_signed = p1_signed[rid];

endmodule

`default_nettype wire

//--- hw/mbiu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mbiu_top #(
   parameter int PORT0_MAX_OT = 4
) (
   input  logic                clk,
   input  logic                rstn,
   // port 0 request, data side
   input  logic                req0_val,
   output logic                req0_rdy,
   input  mbiu_pkg::addr_t     req0_addr,
   input  mbiu_pkg::tag_t      req0_tag,
   input  mbiu_pkg::size_t     req0_size,
   input  logic                req0_signed,
   // port 1 request, instruction side
   input  logic                req1_val,
   output logic                req1_rdy,
   input  mbiu_pkg::addr_t     req1_addr,
   input  mbiu_pkg::tag_t      req1_tag,
   input  mbiu_pkg::size_t     req1_size,
   input  logic                req1_signed,
   // port 0 response
   output logic                rsp0_val,
   input  logic                rsp0_rdy,
   output mbiu_pkg::data_t     rsp0_data,
   output mbiu_pkg::tag_t      rsp0_tag,
   output mbiu_pkg::size_t     rsp0_size,
   output logic                rsp0_signed,
   // port 1 response
   output logic                rsp1_val,
   input  logic                rsp1_rdy,
   output mbiu_pkg::data_t     rsp1_data,
   output mbiu_pkg::tag_t      rsp1_tag,
   output mbiu_pkg::size_t     rsp1_size,
   output logic                rsp1_signed,
   // AXI read address channel
   output logic                arvalid,
   input  logic                arready,
   output mbiu_pkg::axi_id_t   arid,
   output mbiu_pkg::addr_t     araddr,
   output logic [7:0]          arlen,
   output logic [2:0]          arsize,
   output logic [1:0]          arburst,
   output logic [3:0]          arcache,
   output mbiu_pkg::prot_t     arprot,
   // AXI read data channel, rlast unused for single beats
   input  logic                rvalid,
   output logic                rready,
   input  mbiu_pkg::axi_id_t   rid,
   input  mbiu_pkg::data_t     rdata,
   input  logic                rlast
);

   localparam int NP = mbiu_pkg::NUM_PORTS;

   // per port request, core side
   logic [NP-1:0]     req_val;
   logic [NP-1:0]     req_rdy;
   logic [NP-1:0]     req_signed;
   mbiu_pkg::addr_t   req_addr [NP];
   mbiu_pkg::tag_t    req_tag  [NP];
   mbiu_pkg::size_t   req_size [NP];

   // per port request, arbiter side
   logic [NP-1:0]     buf_val;
   logic [NP-1:0]     buf_rdy;
   logic [NP-1:0]     buf_signed;
   mbiu_pkg::addr_t   buf_addr [NP];
   mbiu_pkg::tag_t    buf_tag  [NP];
   mbiu_pkg::size_t   buf_size [NP];

   // issue to tracking
   logic              issue_val;
   logic              issue_port;
   mbiu_pkg::axi_id_t issue_id;
   mbiu_pkg::offs_t   issue_offs;
   mbiu_pkg::tag_t    issue_tag;
   mbiu_pkg::size_t   issue_size;
   logic              issue_signed;
   logic              port0_space;
   logic              port1_done;

   assign req_val    = {req1_val, req0_val};
   assign req_signed = {req1_signed, req0_signed};
   assign req_addr   = '{req0_addr, req1_addr};
   assign req_tag    = '{req0_tag, req1_tag};
   assign req_size   = '{req0_size, req1_size};
   assign req0_rdy   = req_rdy[0];
   assign req1_rdy   = req_rdy[1];

   // ----------------------------------------------------------------------
   // one request buffer per core port
   // ----------------------------------------------------------------------
   for (genvar p = 0; p < NP; p++) begin : g_req_buf
      mbiu_req_buf u_req_buf (
         .clk        (clk),
         .rstn       (rstn),
         .in_val     (req_val[p]),
         .in_rdy     (req_rdy[p]),
         .in_addr    (req_addr[p]),
         .in_tag     (req_tag[p]),
         .in_size    (req_size[p]),
         .in_signed  (req_signed[p]),
         .out_val    (buf_val[p]),
         .out_rdy    (buf_rdy[p]),
         .out_addr   (buf_addr[p]),
         .out_tag    (buf_tag[p]),
         .out_size   (buf_size[p]),
         .out_signed (buf_signed[p])
      );
   end

   // ----------------------------------------------------------------------
   // arbitration and AR
   // ----------------------------------------------------------------------
   mbiu_rd_issue u_rd_issue (
      .clk          (clk),
      .rstn         (rstn),
      .buf0_val     (buf_val[0]),
      .buf0_rdy     (buf_rdy[0]),
      .buf0_addr    (buf_addr[0]),
      .buf0_tag     (buf_tag[0]),
      .buf0_size    (buf_size[0]),
      .buf0_signed  (buf_signed[0]),
      .buf1_val     (buf_val[1]),
      .buf1_rdy     (buf_rdy[1]),
      .buf1_addr    (buf_addr[1]),
      .buf1_tag     (buf_tag[1]),
      .buf1_size    (buf_size[1]),
      .buf1_signed  (buf_signed[1]),
      .port0_space  (port0_space),
      .port1_done   (port1_done),
      .arvalid      (arvalid),
      .arready      (arready),
      .arid         (arid),
      .araddr       (araddr),
      .arlen        (arlen),
      .arsize       (arsize),
      .arburst      (arburst),
      .arcache      (arcache),
      .arprot       (arprot),
      .issue_val    (issue_val),
      .issue_port   (issue_port),
      .issue_id     (issue_id),
      .issue_offs   (issue_offs),
      .issue_tag    (issue_tag),
      .issue_size   (issue_size),
      .issue_signed (issue_signed)
   );

   // ----------------------------------------------------------------------
   // read info and R return path
   // ----------------------------------------------------------------------
   mbiu_rd_track #(
      .PORT0_MAX_OT (PORT0_MAX_OT)
   ) u_rd_track (
      .clk          (clk),
      .rstn         (rstn),
      .issue_val    (issue_val),
      .issue_port   (issue_port),
      .issue_id     (issue_id),
      .issue_offs   (issue_offs),
      .issue_tag    (issue_tag),
      .issue_size   (issue_size),
      .issue_signed (issue_signed),
      .port0_space  (port0_space),
      .port1_done   (port1_done),
      .rvalid       (rvalid),
      .rready       (rready),
      .rid          (rid),
      .rdata        (rdata),
      .rsp0_val     (rsp0_val),
      .rsp0_rdy     (rsp0_rdy),
      .rsp0_data    (rsp0_data),
      .rsp0_tag     (rsp0_tag),
      .rsp0_size    (rsp0_size),
      .rsp0_signed  (rsp0_signed),
      .rsp1_val     (rsp1_val),
      .rsp1_rdy     (rsp1_rdy),
      .rsp1_data    (rsp1_data),
      .rsp1_tag     (rsp1_tag),
      .rsp1_size    (rsp1_size),
      .rsp1_signed  (rsp1_signed)
   );

endmodule

`default_nettype wire

//--- verif/mbiu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mbiu_tb;

   localparam int CLK_NS    = 4;
   localparam int PORT_REQS = 150;
   localparam int TOTAL     = 2 * PORT_REQS;
   // port 1 ids 0 to 6, 7 is port 0
   localparam int P1_IDS    = 7;
   // request record {signed, size, tag, addr}
   localparam int REC_W     = 40;

   logic              clk;
   logic              rstn;
   logic              req0_val;
   logic              req0_rdy;
   mbiu_pkg::addr_t   req0_addr;
   mbiu_pkg::tag_t    req0_tag;
   mbiu_pkg::size_t   req0_size;
   logic              req0_signed;
   logic              req1_val;
   logic              req1_rdy;
   mbiu_pkg::addr_t   req1_addr;
   mbiu_pkg::tag_t    req1_tag;
   mbiu_pkg::size_t   req1_size;
   logic              req1_signed;
   logic              rsp0_val;
   logic              rsp0_rdy;
   mbiu_pkg::data_t   rsp0_data;
   mbiu_pkg::tag_t    rsp0_tag;
   mbiu_pkg::size_t   rsp0_size;
   logic              rsp0_signed;
   logic              rsp1_val;
   logic              rsp1_rdy;
   mbiu_pkg::data_t   rsp1_data;
   mbiu_pkg::tag_t    rsp1_tag;
   mbiu_pkg::size_t   rsp1_size;
   logic              rsp1_signed;
   logic              arvalid;
   logic              arready;
   mbiu_pkg::axi_id_t arid;
   mbiu_pkg::addr_t   araddr;
   logic [7:0]        arlen;
   logic [2:0]        arsize;
   logic [1:0]        arburst;
   logic [3:0]        arcache;
   mbiu_pkg::prot_t   arprot;
   logic              rvalid;
   logic              rready;
   mbiu_pkg::axi_id_t rid;
   mbiu_pkg::data_t   rdata;
   logic              rlast;

   // model state
   logic [31:0]       lcg_state;
   logic [REC_W-1:0]  ar0_q [$];
   logic [REC_W-1:0]  exp0_q [$];
   logic [REC_W-1:0]  ar1_q [$];
   int                ar1_seq_q [$];
   // AXI slave pending list
   logic [REC_W-1:0]  pend_rec [$];
   mbiu_pkg::axi_id_t pend_id [$];
   int                pend_seq [$];
   bit                p1_done [PORT_REQS];
   int                sent0;
   int                sent1;
   int                done_cnt;
   int                p1_inflight;
   int                r_idx;
   mbiu_pkg::axi_id_t exp_p1_id;
   logic              xfer0;
   logic              xfer1;
   logic              rxfer;

   mbiu_top #(
      .PORT0_MAX_OT (4)
   ) dut0 (.*);

   // ----------------------------------------------------------------------
   // random numbers and reference data
   // ----------------------------------------------------------------------
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // true with probability num/16
   function automatic logic draw_chance(input int num);
      logic [31:0] r;
      r = next_random();
      return int'(r[31:28]) < num;
   endfunction

   // word address high, its inverse low
   function automatic mbiu_pkg::data_t model_word(input mbiu_pkg::addr_t addr);
      logic [31:0] wa;
      wa = addr >> 3;
      return {wa, ~wa};
   endfunction

   // requested bytes land at bit 0
   function automatic mbiu_pkg::data_t aligned_data(input mbiu_pkg::addr_t addr);
      return model_word(addr) >> (8 * int'(addr[2:0]));
   endfunction

   task automatic make_request(output mbiu_pkg::addr_t addr, output mbiu_pkg::tag_t tag,
                               output mbiu_pkg::size_t size, output logic sgn);
      logic [31:0] r;
      r    = next_random();
      size = r[31:30];
      tag  = r[29:25];
      sgn  = r[24];
      r    = next_random();
      // aligned to its size, so never crosses a beat
      addr = r & ~((32'd1 << size) - 32'd1);
   endtask

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   task automatic stop_on_failure(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         stop_on_failure($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic check_rsp(input int port, input logic [REC_W-1:0] rec);
      string pfx;
      pfx = (port == 0) ? "rsp0" : "rsp1";
      if (port == 0) begin
         compare({pfx, "_data"}, rsp0_data, aligned_data(rec[31:0]));
         compare({pfx, "_tag"}, 64'(rsp0_tag), 64'(rec[36:32]));
         compare({pfx, "_size"}, 64'(rsp0_size), 64'(rec[38:37]));
         compare({pfx, "_signed"}, 64'(rsp0_signed), 64'(rec[39]));
      end else begin
         compare({pfx, "_data"}, rsp1_data, aligned_data(rec[31:0]));
         compare({pfx, "_tag"}, 64'(rsp1_tag), 64'(rec[36:32]));
         compare({pfx, "_size"}, 64'(rsp1_size), 64'(rec[38:37]));
         compare({pfx, "_signed"}, 64'(rsp1_signed), 64'(rec[39]));
      end
   endtask

   // ----------------------------------------------------------------------
   // stimulus, falling edge
   // ----------------------------------------------------------------------
   task automatic drive_requests();
      if (xfer0) begin
         req0_val = 1'b0;
      end
      if (!req0_val && sent0 < PORT_REQS && draw_chance(8)) begin
         make_request(req0_addr, req0_tag, req0_size, req0_signed);
         req0_val = 1'b1;
      end
      if (xfer1) begin
         req1_val = 1'b0;
      end
      // ids repeat every 7 port 1 reads, the one 7 back must have returned
      if (!req1_val && sent1 < PORT_REQS && draw_chance(8) &&
          (sent1 < P1_IDS || p1_done[sent1 - P1_IDS])) begin
         make_request(req1_addr, req1_tag, req1_size, req1_signed);
         req1_val = 1'b1;
      end
   endtask

   task automatic drive_slave();
      int idx;
      arready  = draw_chance(12);
      rsp0_rdy = draw_chance(12);
      rsp1_rdy = draw_chance(12);
      if (rxfer) begin
         rvalid = 1'b0;
      end
      if (!rvalid && pend_rec.size() > 0 && draw_chance(12)) begin
         idx = int'((next_random() >> 8) % pend_rec.size());
         // port 0 stays in order
         if (pend_id[idx] == 3'd7) begin
            idx = 0;
            while (pend_id[idx] != 3'd7) begin
               idx++;
            end
         end
         r_idx  = idx;
         rvalid = 1'b1;
         rid    = pend_id[idx];
         rdata  = model_word(pend_rec[idx][31:0]);
         rlast  = 1'b1;
      end
   endtask

   // ----------------------------------------------------------------------
   // sampling, mid cycle, before the next rising edge
   // ----------------------------------------------------------------------
   task automatic observe();
      logic [REC_W-1:0] rec;
      int               seq;
      compare("rsp0_val", 64'(rsp0_val), 64'(rvalid && rid == 3'd7));
      compare("rsp1_val", 64'(rsp1_val), 64'(rvalid && rid != 3'd7));
      if (rvalid) begin
         compare("rready", 64'(rready), 64'((rid == 3'd7) ? rsp0_rdy : rsp1_rdy));
      end
      xfer0 = req0_val && req0_rdy;
      xfer1 = req1_val && req1_rdy;
      rxfer = rvalid && rready;
      if (xfer0) begin
         ar0_q.push_back({req0_signed, req0_size, req0_tag, req0_addr});
         exp0_q.push_back({req0_signed, req0_size, req0_tag, req0_addr});
         sent0++;
      end
      if (xfer1) begin
         ar1_q.push_back({req1_signed, req1_size, req1_tag, req1_addr});
         ar1_seq_q.push_back(sent1);
         sent1++;
      end
      // R before AR, so pending indices stay valid
      if (rxfer) begin
         if (rid == 3'd7) begin
            if (exp0_q.size() == 0) begin
               stop_on_failure("port 0 returned a response with no open request");
            end
            rec = exp0_q.pop_front();
            check_rsp(0, rec);
         end else begin
            check_rsp(1, pend_rec[r_idx]);
            p1_done[pend_seq[r_idx]] = 1'b1;
            p1_inflight--;
         end
         pend_rec.delete(r_idx);
         pend_id.delete(r_idx);
         pend_seq.delete(r_idx);
         done_cnt++;
      end
      if (arvalid && arready) begin
         compare("arlen", 64'(arlen), 64'd0);
         compare("arsize", 64'(arsize), 64'd3);
         compare("arburst", 64'(arburst), 64'd1);
         compare("arcache", 64'(arcache), 64'd1);
         if (arid == 3'd7) begin
            compare("arprot", 64'(arprot), 64'd0);
            if (ar0_q.size() == 0) begin
               stop_on_failure("port 0 read issued with no request behind it");
            end
            rec = ar0_q.pop_front();
            seq = -1;
         end else begin
            compare("arid", 64'(arid), 64'(exp_p1_id));
            compare("arprot", 64'(arprot), 64'd4);
            if (ar1_q.size() == 0) begin
               stop_on_failure("port 1 read issued with no request behind it");
            end
            rec = ar1_q.pop_front();
            seq = ar1_seq_q.pop_front();
            exp_p1_id = (exp_p1_id == 3'd6) ? 3'd0 : exp_p1_id + 3'd1;
            p1_inflight++;
            if (p1_inflight > P1_IDS) begin
               stop_on_failure("more than 7 port 1 reads in flight");
            end
         end
         compare("araddr", 64'(araddr), 64'(rec[31:0]));
         pend_rec.push_back(rec);
         pend_id.push_back(arid);
         pend_seq.push_back(seq);
      end
   endtask

   task automatic run_cycle();
      @(negedge clk);
      drive_requests();
      drive_slave();
      #1;
      observe();
   endtask

   // ----------------------------------------------------------------------
   // clock, watchdog, main sequence
   // ----------------------------------------------------------------------
   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // 400 cycles per request
   initial begin
      #(CLK_NS * 400 * TOTAL);
      stop_on_failure("timeout, the responses did not finish");
   end

   initial begin
      lcg_state   = 32'h0119934e;
      rstn        = 1'b0;
      req0_val    = 1'b0;
      req0_addr   = '0;
      req0_tag    = '0;
      req0_size   = '0;
      req0_signed = 1'b0;
      req1_val    = 1'b0;
      req1_addr   = '0;
      req1_tag    = '0;
      req1_size   = '0;
      req1_signed = 1'b0;
      rsp0_rdy    = 1'b0;
      rsp1_rdy    = 1'b0;
      arready     = 1'b0;
      rvalid      = 1'b0;
      rid         = '0;
      rdata       = '0;
      rlast       = 1'b0;
      sent0       = 0;
      sent1       = 0;
      done_cnt    = 0;
      p1_inflight = 0;
      r_idx       = 0;
      exp_p1_id   = '0;
      xfer0       = 1'b0;
      xfer1       = 1'b0;
      rxfer       = 1'b0;
      // two rising edges in reset
      repeat (2) @(negedge clk);
      rstn = 1'b1;
      #1;
      // idle state out of reset
      compare("arvalid", 64'(arvalid), 64'd0);
      compare("rsp0_val", 64'(rsp0_val), 64'd0);
      compare("rsp1_val", 64'(rsp1_val), 64'd0);
      compare("req0_rdy", 64'(req0_rdy), 64'd1);
      compare("req1_rdy", 64'(req1_rdy), 64'd1);
      while (done_cnt < TOTAL) begin
         run_cycle();
      end
      // a stray read would show up here
      repeat (10) begin
         run_cycle();
      end
      if (done_cnt == TOTAL && sent0 == PORT_REQS && sent1 == PORT_REQS &&
          ar0_q.size() == 0 && ar1_q.size() == 0 && exp0_q.size() == 0 &&
          pend_rec.size() == 0) begin
         $display("test passed");
         $finish;
      end else begin
         stop_on_failure("requests and responses do not balance at the end");
      end
   end

endmodule

`default_nettype wire

//--- build.f
common/mbiu_pkg.sv
hw/mbiu_req_buf.sv
hw/mbiu_rd_issue.sv
hw/mbiu_rd_track.sv
hw/mbiu_top.sv
verif/mbiu_tb.sv

//--- Makefile
TOP := mbiu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
